// File: core_pkg.sv
package core_pkg;

    // Widths that carry a meaning in the slice.
    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  alu_op_t;

    // ALU operation select.
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_PASS = 4'd7;

    // 3R format, opcode in bits 31..15.
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_SLTU  = 17'h00025;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits 31..22.
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;

    // 1RI20 format, opcode in bits 31..25.
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    // Decoded operation handed from issue to execute.
    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rd;
        logic     wen;
        logic     illegal;
        u32_t     src_a;
        u32_t     src_b;
    } issue_t;

    // Record emitted when an operation retires.
    typedef struct packed {
        reg_idx_t rd;
        logic     wen;
        logic     illegal;
        u32_t     value;
    } retire_t;

endpackage

// File: reg_file.sv
module reg_file (
    input  logic              clk,
    input  logic              rst_n,

    input  core_pkg::reg_idx_t rj,
    input  core_pkg::reg_idx_t rkd,
    output core_pkg::u32_t     rj_data,
    output core_pkg::u32_t     rkd_data,

    input  logic              we,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::u32_t     rd_data
);

    import core_pkg::*;

    u32_t regs [32];
    logic fwd_en;

    // Bypass only real writes, r0 never takes a value.
    assign fwd_en = we && (rd != 5'd0);

    always_comb begin
        if (fwd_en && (rj == rd)) begin
            rj_data = rd_data;
        end else begin
            rj_data = regs[rj];
        end
    end

    always_comb begin
        if (fwd_en && (rkd == rd)) begin
            rkd_data = rd_data;
        end else begin
            rkd_data = regs[rkd];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0] <= '0;
        end else if (fwd_en) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

// File: issue_stage.sv
module issue_stage (
    input  logic                inst_valid,
    output logic                inst_ready,
    input  core_pkg::inst_t     inst,

    output logic                iss_valid,
    input  logic                iss_ready,
    output core_pkg::issue_t    iss,

    output core_pkg::reg_idx_t  rj,
    output core_pkg::reg_idx_t  rkd,
    input  core_pkg::u32_t      rj_data,
    input  core_pkg::u32_t      rkd_data
);

    import core_pkg::*;

    logic [16:0] opc_3r;
    logic [9:0]  opc_2ri12;
    logic [6:0]  opc_1ri20;
    reg_idx_t    rd;
    u32_t        imm_si12;
    u32_t        imm_ui20;

    alu_op_t     op;
    logic        legal;
    u32_t        src_b;

    // Straight pass of the handshake, the stage holds no state.
    assign inst_ready = iss_ready;
    assign iss_valid  = inst_valid;

    assign opc_3r    = inst[31:15];
    assign opc_2ri12 = inst[31:22];
    assign opc_1ri20 = inst[31:25];

    // Field positions are common to all three formats.
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rkd = inst[14:10];

    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui20 = {inst[24:5], 12'd0};

    always_comb begin
        op    = ALU_PASS;
        legal = 1'b1;
        src_b = rkd_data;
        case (opc_3r)
            OPC_ADD_W: op = ALU_ADD;
            OPC_SUB_W: op = ALU_SUB;
            OPC_SLT:   op = ALU_SLT;
            OPC_SLTU:  op = ALU_SLTU;
            OPC_AND:   op = ALU_AND;
            OPC_OR:    op = ALU_OR;
            OPC_XOR:   op = ALU_XOR;
            default: begin
                if (opc_2ri12 == OPC_ADDI_W) begin
                    op    = ALU_ADD;
                    src_b = imm_si12;
                end else if (opc_1ri20 == OPC_LU12I_W) begin
                    // Result is operand b itself.
                    op    = ALU_PASS;
                    src_b = imm_ui20;
                end else begin
                    legal = 1'b0;
                end
            end
        endcase
    end

    always_comb begin
        iss.op      = op;
        iss.rd      = rd;
        iss.wen     = legal && (rd != 5'd0);
        iss.illegal = !legal;
        iss.src_a   = rj_data;
        iss.src_b   = src_b;
    end

endmodule

// File: issue_buffer.sv
module issue_buffer (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             iss_valid,
    output logic             iss_ready,
    input  core_pkg::issue_t iss,

    output logic             ex_valid,
    input  logic             ex_ready,
    output core_pkg::issue_t ex
);

    import core_pkg::*;

    logic   full;
    issue_t entry;

    // The entry can be replaced on the edge it drains.
    assign iss_ready = !full || ex_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (iss_ready) begin
            full <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            entry <= iss;
        end
    end

    assign ex_valid = full;
    assign ex       = entry;

endmodule

// File: exec_stage.sv
module exec_stage (
    input  logic               ex_valid,
    output logic               ex_ready,
    input  core_pkg::issue_t   ex,

    output logic               ret_valid,
    input  logic               ret_ready,
    output core_pkg::retire_t  ret,

    output logic               we,
    output core_pkg::reg_idx_t rd,
    output core_pkg::u32_t     rd_data
);

    import core_pkg::*;

    u32_t result;
    u32_t value;

    always_comb begin
        case (ex.op)
            ALU_ADD:  result = ex.src_a + ex.src_b;
            ALU_SUB:  result = ex.src_a - ex.src_b;
            ALU_SLT:  result = {31'd0, $signed(ex.src_a) < $signed(ex.src_b)};
            ALU_SLTU: result = {31'd0, ex.src_a < ex.src_b};
            ALU_AND:  result = ex.src_a & ex.src_b;
            ALU_OR:   result = ex.src_a | ex.src_b;
            ALU_XOR:  result = ex.src_a ^ ex.src_b;
            default:  result = ex.src_b;
        endcase
    end

    // Illegal operations report a zero value.
    assign value = ex.illegal ? '0 : result;

    assign ret_valid = ex_valid;
    assign ex_ready  = ret_ready;

    always_comb begin
        ret.rd      = ex.rd;
        ret.wen     = ex.wen;
        ret.illegal = ex.illegal;
        ret.value   = value;
    end

    // Write back only on the retire transfer.
    assign we      = ex_valid && ret_ready && ex.wen;
    assign rd      = ex.rd;
    assign rd_data = value;

endmodule

// File: int_slice_top.sv
module int_slice_top (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              inst_valid,
    output logic              inst_ready,
    input  core_pkg::inst_t   inst,

    output logic              ret_valid,
    input  logic              ret_ready,
    output core_pkg::retire_t ret
);

    import core_pkg::*;

    logic     iss_valid;
    logic     iss_ready;
    issue_t   iss;

    logic     ex_valid;
    logic     ex_ready;
    issue_t   ex;

    reg_idx_t rj;
    reg_idx_t rkd;
    u32_t     rj_data;
    u32_t     rkd_data;

    logic     we;
    reg_idx_t rd;
    u32_t     rd_data;

    issue_stage issue_stage_inst (
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss        (iss),
        .rj         (rj),
        .rkd        (rkd),
        .rj_data    (rj_data),
        .rkd_data   (rkd_data)
    );

    issue_buffer issue_buffer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss       (iss),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .ex        (ex)
    );

    exec_stage exec_stage_inst (
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .ex        (ex),
        .ret_valid (ret_valid),
        .ret_ready (ret_ready),
        .ret       (ret),
        .we        (we),
        .rd        (rd),
        .rd_data   (rd_data)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rj       (rj),
        .rkd      (rkd),
        .rj_data  (rj_data),
        .rkd_data (rkd_data),
        .we       (we),
        .rd       (rd),
        .rd_data  (rd_data)
    );

endmodule

// File: int_slice_chk.sv
module int_slice_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              inst_valid,
    input logic              inst_ready,
    input core_pkg::inst_t   inst,
    input logic              ret_valid,
    input logic              ret_ready,
    input core_pkg::retire_t ret
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // A stalled instruction must wait unchanged.
    inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst))
        else begin
            $error("instruction dropped or changed while stalled");
            fail_count++;
        end

    ret_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && !ret_ready |=> ret_valid && $stable(ret))
        else begin
            $error("retire record dropped or changed while stalled");
            fail_count++;
        end

    // Nothing retires out of reset.
    ret_idle: assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> !ret_valid)
        else begin
            $error("retire valid high in or right after reset");
            fail_count++;
        end

    illegal_no_wen: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && ret.illegal |-> !ret.wen)
        else begin
            $error("illegal record carries a register write");
            fail_count++;
        end

    wen_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && ret.wen |-> ret.rd != 5'd0)
        else begin
            $error("record writes r0");
            fail_count++;
        end

endmodule

bind int_slice_top int_slice_chk int_slice_chk_inst (.*);

// File: int_slice_tb.sv
module int_slice_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int N_LUI       = 4;
    localparam int N_INIT      = 31 + N_LUI;
    localparam int N_ALU       = 60;
    localparam int N_CHAINS    = 4;
    localparam int CHAIN_LEN   = 10;
    localparam int N_BP        = 80;
    localparam int N_ILL       = 16;
    localparam int N_R0        = 8;
    localparam int N_READ      = 8;
    localparam int TOTAL_INST  = N_INIT + N_ALU + N_CHAINS * CHAIN_LEN + N_BP
                                 + N_ILL + N_R0 + N_READ;
    localparam int CYCLE_LIMIT = 4 * TOTAL_INST + 200;

    localparam logic [31:0] LFSR_SEED = 32'd84588;
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic        inst_ready;
    inst_t       inst;
    logic        ret_valid;
    logic        ret_ready;
    retire_t     ret;

    logic [31:0] stim_lfsr;
    logic [31:0] bp_lfsr;
    logic        bp_on;
    u32_t        model [32];
    retire_t     exp_q [$];
    retire_t     exp_rec;
    string       cur_test;
    int          test_count;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          cycles;

    int_slice_top int_slice_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .ret_valid  (ret_valid),
        .ret_ready  (ret_ready),
        .ret        (ret)
    );

    // Galois LFSR stepped once per bit handed out.
    function automatic logic [31:0] lfsr_bits(ref logic [31:0] state, input int n);
        logic [31:0] bits;
        logic        out;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            out   = state[0];
            state = state >> 1;
            if (out) begin
                state = state ^ LFSR_TAPS;
            end
            bits = {bits[30:0], out};
        end
        return bits;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        return lfsr_bits(stim_lfsr, n);
    endfunction

    // 0..6 are the 3R kinds, 7 addi.w, 8 lu12i.w, -1 unknown.
    function automatic int op_kind(input inst_t w);
        case (w[31:15])
            OPC_ADD_W: return 0;
            OPC_SUB_W: return 1;
            OPC_SLT:   return 2;
            OPC_SLTU:  return 3;
            OPC_AND:   return 4;
            OPC_OR:    return 5;
            OPC_XOR:   return 6;
            default:   ;
        endcase
        if (w[31:22] == OPC_ADDI_W) begin
            return 7;
        end
        if (w[31:25] == OPC_LU12I_W) begin
            return 8;
        end
        return -1;
    endfunction

    function automatic retire_t ref_model(input inst_t w, ref u32_t m [32]);
        retire_t r;
        int      kind;
        u32_t    a;
        u32_t    b;
        u32_t    v;
        kind = op_kind(w);
        a    = m[w[9:5]];
        b    = m[w[14:10]];
        case (kind)
            0:       v = a + b;
            1:       v = a - b;
            2:       v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3:       v = (a < b) ? 32'd1 : 32'd0;
            4:       v = a & b;
            5:       v = a | b;
            6:       v = a ^ b;
            7:       v = a + {{20{w[21]}}, w[21:10]};
            8:       v = {w[24:5], 12'd0};
            default: v = '0;
        endcase
        r.rd      = w[4:0];
        r.illegal = (kind < 0);
        r.wen     = !r.illegal && (w[4:0] != 5'd0);
        r.value   = v;
        if (r.wen) begin
            m[w[4:0]] = v;
        end
        return r;
    endfunction

    function automatic logic [16:0] opc_3r_of(input int k);
        case (k)
            0:       return OPC_ADD_W;
            1:       return OPC_SUB_W;
            2:       return OPC_SLT;
            3:       return OPC_SLTU;
            4:       return OPC_AND;
            5:       return OPC_OR;
            default: return OPC_XOR;
        endcase
    endfunction

    function automatic inst_t enc_3r(input logic [16:0] opc, input reg_idx_t rd,
                                     input reg_idx_t rj, input reg_idx_t rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic inst_t enc_addi(input reg_idx_t rd, input reg_idx_t rj,
                                       input logic [11:0] imm);
        return {OPC_ADDI_W, imm, rj, rd};
    endfunction

    function automatic inst_t enc_lu12i(input reg_idx_t rd, input logic [19:0] imm);
        return {OPC_LU12I_W, imm, rd};
    endfunction

    function automatic int rand_kind();
        int k;
        do begin
            k = int'(take_bits(3));
        end while (k == 7);
        return k;
    endfunction

    function automatic reg_idx_t rand_reg_nz();
        reg_idx_t r;
        do begin
            r = 5'(take_bits(5));
        end while (r == 5'd0);
        return r;
    endfunction

    function automatic inst_t random_inst();
        logic [2:0] sel;
        reg_idx_t   rd;
        reg_idx_t   rj;
        reg_idx_t   rk;
        sel = 3'(take_bits(3));
        rd  = 5'(take_bits(5));
        rj  = 5'(take_bits(5));
        if (sel == 3'd6) begin
            return enc_addi(rd, rj, 12'(take_bits(12)));
        end else if (sel == 3'd7) begin
            return enc_lu12i(rd, 20'(take_bits(20)));
        end
        rk = 5'(take_bits(5));
        return enc_3r(opc_3r_of(rand_kind()), rd, rj, rk);
    endfunction

    function automatic string rec_text(input retire_t r);
        return $sformatf("rd=%0d wen=%0b illegal=%0b value=%08h",
                         r.rd, r.wen, r.illegal, r.value);
    endfunction

    // Holds valid until the slice takes the word; the caller drops it.
    task automatic issue_inst(input inst_t w);
        logic taken;
        exp_q.push_back(ref_model(w, model));
        inst       = w;
        inst_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = inst_ready;
            assert (taken || !ret_ready) else begin
                $display("Stall in %s: inst_ready low while ret_ready high", cur_test);
                test_errors++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic set_backpressure(input logic on);
        @(negedge clk);
        bp_on = on;
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        inst_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        test_count++;
        total_checks += test_checks;
        total_errors += test_errors;
        $display("test %-8s records %0d errors %0d", cur_test, test_checks, test_errors);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4;
            clk = ~clk;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (bp_on) begin
                ret_ready = (lfsr_bits(bp_lfsr, 2) != 0);
            end else begin
                ret_ready = 1'b1;
            end
        end
    end

    // Records are compared at the falling edge ahead of their transfer.
    always begin
        @(negedge clk);
        if (ret_valid && ret_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Retire in %s with no instruction outstanding", cur_test);
                test_errors++;
            end
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                test_checks++;
                assert (ret === exp_rec) else begin
                    $display("Mismatch in %s: expected %s, actual %s",
                             cur_test, rec_text(exp_rec), rec_text(ret));
                    test_errors++;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout in %s after %0d cycles", cur_test, cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        inst_t    w;
        reg_idx_t rd_i;
        reg_idx_t rk_i;
        reg_idx_t prev;
        int       n;
        int       c;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        ret_ready  = 1'b1;
        bp_on      = 1'b0;
        stim_lfsr  = LFSR_SEED;
        bp_lfsr    = LFSR_SEED;
        for (n = 0; n < 32; n++) begin
            model[n] = '0;
        end
        test_count   = 0;
        total_checks = 0;
        total_errors = 0;
        start_test("reset");
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test("init");
        for (n = 1; n < 32; n++) begin
            issue_inst(enc_addi(5'(n), 5'd0, 12'(take_bits(12))));
        end
        for (n = 0; n < N_LUI; n++) begin
            rd_i = rand_reg_nz();
            issue_inst(enc_lu12i(rd_i, 20'(take_bits(20))));
        end
        finish_test();

        start_test("alu");
        for (n = 0; n < N_ALU; n++) begin
            w = enc_3r(opc_3r_of(n % 7), 5'd0, 5'd0, 5'd0);
            w[14:0] = 15'(take_bits(15));
            issue_inst(w);
        end
        finish_test();

        // Every link reads the destination written just before it.
        start_test("chain");
        for (c = 0; c < N_CHAINS; c++) begin
            prev = rand_reg_nz();
            for (n = 0; n < CHAIN_LEN; n++) begin
                rd_i = rand_reg_nz();
                if (take_bits(1) != 0) begin
                    issue_inst(enc_addi(rd_i, prev, 12'(take_bits(12))));
                end else begin
                    // Register-register links read it through the rk port.
                    rk_i = 5'(take_bits(5));
                    issue_inst(enc_3r(opc_3r_of(rand_kind()), rd_i, rk_i, prev));
                end
                prev = rd_i;
            end
        end
        finish_test();

        start_test("backpr");
        set_backpressure(1'b1);
        for (n = 0; n < N_BP; n++) begin
            issue_inst(random_inst());
        end
        finish_test();
        set_backpressure(1'b0);

        start_test("illegal");
        for (n = 0; n < N_ILL; n++) begin
            do begin
                w = take_bits(32);
            end while (op_kind(w) >= 0);
            issue_inst(w);
        end
        for (n = 0; n < N_R0; n++) begin
            w = random_inst();
            w[4:0] = 5'd0;
            issue_inst(w);
        end
        for (n = 0; n < N_READ; n++) begin
            rd_i = rand_reg_nz();
            rk_i = 5'(take_bits(5));
            if (n % 2 == 0) begin
                issue_inst(enc_3r(OPC_ADD_W, rd_i, 5'd0, 5'd0));
            end else begin
                issue_inst(enc_3r(OPC_OR, rd_i, 5'd0, rk_i));
            end
        end
        finish_test();

        total_errors += int_slice_top_inst.int_slice_chk_inst.fail_count;
        $display("%0d tests, %0d records checked, %0d errors",
                 test_count, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: compile.f
core_pkg.sv
reg_file.sv
issue_stage.sv
issue_buffer.sv
exec_stage.sv
int_slice_top.sv
int_slice_chk.sv
int_slice_tb.sv
